//--- Bender.yml
package:
  name: axi_mem

sources:
  - axi_pkg.sv
  - mem_pkg.sv
  - axi_read_engine.sv
  - axi_write_engine.sv
  - shared_mem.sv
  - axi_mem_top.sv
  - target: test
    files:
      - tb_axi_mem.sv

//--- axi_mem_top.sv
`timescale 1ns/10ps

module axi_mem_top
  import axi_pkg::*, mem_pkg::*;
#(
  parameter int unsigned mem_addr_bits = 10
) (
  input  logic   clock,
  input  logic   reset,

  input  id_t    awid,
  input  addr_t  awaddr,
  input  len_t   awlen,
  input  burst_t awburst,
  input  logic   awvalid,
  output logic   awready,

  input  data_t  wdata,
  input  strb_t  wstrb,
  input  logic   wlast,
  input  logic   wvalid,
  output logic   wready,

  output id_t    bid,
  output resp_t  bresp,
  output logic   bvalid,
  input  logic   bready,

  input  id_t    arid,
  input  addr_t  araddr,
  input  len_t   arlen,
  input  burst_t arburst,
  input  logic   arvalid,
  output logic   arready,

  output id_t    rid,
  output data_t  rdata,
  output resp_t  rresp,
  output logic   rlast,
  output logic   rvalid,
  input  logic   rready
);

  logic      rd_req;
  logic      rd_gnt;
  word_idx_t rd_idx;
  data_t     rd_word;

  logic      wr_req;
  logic      wr_gnt;
  word_idx_t wr_idx;
  data_t     wr_word;
  strb_t     wr_strb;

  axi_read_engine #(
    .mem_addr_bits(mem_addr_bits)
  ) i_read_engine (
    .clock  (clock),
    .reset  (reset),
    .arid   (arid),
    .araddr (araddr),
    .arlen  (arlen),
    .arburst(arburst),
    .arvalid(arvalid),
    .arready(arready),
    .rid    (rid),
    .rdata  (rdata),
    .rresp  (rresp),
    .rlast  (rlast),
    .rvalid (rvalid),
    .rready (rready),
    .rd_req (rd_req),
    .rd_idx (rd_idx),
    .rd_gnt (rd_gnt),
    .rd_word(rd_word)
  );

  axi_write_engine #(
    .mem_addr_bits(mem_addr_bits)
  ) i_write_engine (
    .clock  (clock),
    .reset  (reset),
    .awid   (awid),
    .awaddr (awaddr),
    .awlen  (awlen),
    .awburst(awburst),
    .awvalid(awvalid),
    .awready(awready),
    .wdata  (wdata),
    .wstrb  (wstrb),
    .wlast  (wlast),
    .wvalid (wvalid),
    .wready (wready),
    .bid    (bid),
    .bresp  (bresp),
    .bvalid (bvalid),
    .bready (bready),
    .wr_req (wr_req),
    .wr_idx (wr_idx),
    .wr_word(wr_word),
    .wr_strb(wr_strb),
    .wr_gnt (wr_gnt)
  );

  shared_mem #(
    .mem_addr_bits(mem_addr_bits)
  ) i_shared_mem (
    .clock  (clock),
    .reset  (reset),
    .rd_req (rd_req),
    .rd_idx (rd_idx),
    .rd_gnt (rd_gnt),
    .rd_word(rd_word),
    .wr_req (wr_req),
    .wr_idx (wr_idx),
    .wr_word(wr_word),
    .wr_strb(wr_strb),
    .wr_gnt (wr_gnt)
  );

endmodule

//--- axi_pkg.sv
package axi_pkg;

  // transaction id
  typedef logic [3:0] id_t;

  // burst length minus one, only 0 to 15 are honored
  typedef logic [7:0] len_t;

  // beat size code
  typedef logic [2:0] size_t;

  typedef logic [1:0] burst_t;

  localparam burst_t burst_fixed = 2'b00;
  localparam burst_t burst_incr  = 2'b01;

  typedef logic [1:0] resp_t;

  localparam resp_t resp_okay   = 2'b00;
  localparam resp_t resp_slverr = 2'b10;

  // byte address
  typedef logic [31:0] addr_t;

  typedef logic [31:0] data_t;

  // one strobe per byte lane
  typedef logic [3:0] strb_t;

endpackage

//--- axi_read_engine.sv
`timescale 1ns/10ps

module axi_read_engine
  import axi_pkg::*, mem_pkg::*;
#(
  parameter int unsigned mem_addr_bits = 10
) (
  input  logic      clock,
  input  logic      reset,
  input  id_t       arid,
  input  addr_t     araddr,
  input  len_t      arlen,
  input  burst_t    arburst,
  input  logic      arvalid,
  output logic      arready,
  output id_t       rid,
  output data_t     rdata,
  output resp_t     rresp,
  output logic      rlast,
  output logic      rvalid,
  input  logic      rready,
  output logic      rd_req,
  output word_idx_t rd_idx,
  input  logic      rd_gnt,
  input  data_t     rd_word
);

  typedef enum logic [1:0] {
    st_idle,
    st_fetch,
    st_wait,
    st_present
  } rd_state_t;

  rd_state_t state;

  id_t    rid_q;
  burst_t burst_q;
  data_t  rdata_q;
  resp_t  rresp_q;
  logic [3:0] beats_left;
  logic [$bits(addr_t)-byte_offset_bits-1:0] cur_word;
  logic in_range;

  // word address beyond the storage depth
  assign in_range = (cur_word >> mem_addr_bits) == '0;

  assign arready = (state == st_idle);
  assign rvalid  = (state == st_present);
  assign rlast   = (state == st_present) && (beats_left == '0);
  assign rid     = rid_q;
  assign rdata   = rdata_q;
  assign rresp   = rresp_q;

  assign rd_req = (state == st_fetch) && in_range;
  assign rd_idx = word_idx_t'(cur_word);

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (arvalid) begin
            state <= st_fetch;
          end
        end
        st_fetch: begin
          // out of range beats skip the memory
          if (!in_range) begin
            state <= st_present;
          end else if (rd_gnt) begin
            state <= st_wait;
          end
        end
        st_wait: begin
          state <= st_present;
        end
        st_present: begin
          if (rready) begin
            state <= (beats_left == '0) ? st_idle : st_fetch;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_idle && arvalid) begin
      rid_q      <= arid;
      burst_q    <= arburst;
      beats_left <= arlen[3:0];
      cur_word   <= araddr[$bits(addr_t)-1:byte_offset_bits];
    end
    if (state == st_fetch && !in_range) begin
      rdata_q <= '0;
      rresp_q <= resp_slverr;
    end
    if (state == st_wait) begin
      rdata_q <= rd_word;
      rresp_q <= resp_okay;
    end
    if (state == st_present && rready && beats_left != '0) begin
      beats_left <= beats_left - 1'b1;
      // wrap bursts are treated as incr
      if (burst_q != burst_fixed) begin
        cur_word <= cur_word + 1'b1;
      end
    end
  end

endmodule

//--- axi_write_engine.sv
`timescale 1ns/10ps

module axi_write_engine
  import axi_pkg::*, mem_pkg::*;
#(
  parameter int unsigned mem_addr_bits = 10
) (
  input  logic      clock,
  input  logic      reset,
  input  id_t       awid,
  input  addr_t     awaddr,
  input  len_t      awlen,
  input  burst_t    awburst,
  input  logic      awvalid,
  output logic      awready,
  input  data_t     wdata,
  input  strb_t     wstrb,
  input  logic      wlast,
  input  logic      wvalid,
  output logic      wready,
  output id_t       bid,
  output resp_t     bresp,
  output logic      bvalid,
  input  logic      bready,
  output logic      wr_req,
  output word_idx_t wr_idx,
  output data_t     wr_word,
  output strb_t     wr_strb,
  input  logic      wr_gnt
);

  typedef enum logic [1:0] {
    st_idle,
    st_data,
    st_resp
  } wr_state_t;

  wr_state_t state;

  id_t    bid_q;
  burst_t burst_q;
  logic   err;
  logic [3:0] beats_left;
  logic [$bits(addr_t)-byte_offset_bits-1:0] cur_word;
  logic in_range;
  logic beat_done;
  logic last_beat;

  assign in_range = (cur_word >> mem_addr_bits) == '0;

  // out of range beats are taken at once without touching memory
  assign wready    = (state == st_data) && (in_range ? wr_gnt : 1'b1);
  assign beat_done = wvalid && wready;

  // wlast ends the burst, the beat count guards against a missing wlast
  assign last_beat = wlast || (beats_left == '0);

  assign awready = (state == st_idle);
  assign bvalid  = (state == st_resp);
  assign bid     = bid_q;
  assign bresp   = err ? resp_slverr : resp_okay;

  assign wr_req  = (state == st_data) && wvalid && in_range;
  assign wr_idx  = word_idx_t'(cur_word);
  assign wr_word = wdata;
  assign wr_strb = wstrb;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
      err   <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (awvalid) begin
            state <= st_data;
            err   <= 1'b0;
          end
        end
        st_data: begin
          if (beat_done) begin
            // sticky until the next burst
            if (!in_range) begin
              err <= 1'b1;
            end
            if (last_beat) begin
              state <= st_resp;
            end
          end
        end
        st_resp: begin
          if (bready) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_idle && awvalid) begin
      bid_q      <= awid;
      burst_q    <= awburst;
      beats_left <= awlen[3:0];
      cur_word   <= awaddr[$bits(addr_t)-1:byte_offset_bits];
    end
    if (state == st_data && beat_done) begin
      beats_left <= beats_left - 1'b1;
      // fixed bursts keep hitting the same word
      if (burst_q != burst_fixed) begin
        cur_word <= cur_word + 1'b1;
      end
    end
  end

endmodule

//--- mem_pkg.sv
package mem_pkg;

  // low bits of a byte address that select the lane
  localparam int unsigned byte_offset_bits = 2;

  // bytes per memory word
  localparam int unsigned word_lanes = 4;

  // only the low mem_addr_bits bits are used
  typedef logic [15:0] word_idx_t;

  // current or most recent memory owner
  typedef enum logic [1:0] {
    grant_none  = 2'b00,
    grant_read  = 2'b01,
    grant_write = 2'b10
  } grant_t;

endpackage

//--- shared_mem.sv
`timescale 1ns/10ps

module shared_mem
  import axi_pkg::*, mem_pkg::*;
#(
  parameter int unsigned mem_addr_bits = 10
) (
  input  logic      clock,
  input  logic      reset,
  input  logic      rd_req,
  input  word_idx_t rd_idx,
  output logic      rd_gnt,
  output data_t     rd_word,
  input  logic      wr_req,
  input  word_idx_t wr_idx,
  input  data_t     wr_word,
  input  strb_t     wr_strb,
  output logic      wr_gnt
);

  localparam int unsigned depth = 2 ** mem_addr_bits;

  data_t  storage [0:depth-1];
  data_t  rd_word_q;
  grant_t last_owner;

  // on a tie the side that did not win last time goes first
  assign rd_gnt = rd_req && (!wr_req || last_owner != grant_read);
  assign wr_gnt = wr_req && (!rd_req || last_owner == grant_read);

  assign rd_word = rd_word_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      last_owner <= grant_none;
    end else if (rd_gnt) begin
      last_owner <= grant_read;
    end else if (wr_gnt) begin
      last_owner <= grant_write;
    end
  end

  // byte lane writes
  always_ff @(posedge clock) begin
    if (wr_gnt) begin
      for (int lane = 0; lane < word_lanes; lane++) begin
        if (wr_strb[lane]) begin
          storage[wr_idx[mem_addr_bits-1:0]][lane*8 +: 8] <= wr_word[lane*8 +: 8];
        end
      end
    end
  end

  // registered read, data valid the cycle after the grant
  always_ff @(posedge clock) begin
    if (rd_gnt) begin
      rd_word_q <= storage[rd_idx[mem_addr_bits-1:0]];
    end
  end

endmodule

//--- tb.f
axi_pkg.sv
mem_pkg.sv
axi_read_engine.sv
axi_write_engine.sv
shared_mem.sv
axi_mem_top.sv
tb_axi_mem.sv

//--- tb_axi_mem.sv
`timescale 1ns/10ps

module tb_axi_mem
  import axi_pkg::*, mem_pkg::*;
;

  localparam int unsigned mem_addr_bits  = 10;
  localparam int unsigned mem_words      = 1 << mem_addr_bits;
  localparam int          n_rows         = 16;
  localparam int          cycles_per_row = 40;
  localparam int          clock_period   = 8;

  typedef enum logic [1:0] {op_write, op_read, op_both} op_t;

  // resp only applies to writes since read beats derive theirs from the address
  typedef struct packed {
    op_t        kind;
    id_t        id;
    addr_t      addr;
    len_t       len;
    burst_t     burst;
    logic [7:0] data_seed;
    strb_t      strb;
    resp_t      resp;
  } row_t;

  logic   clock;
  logic   reset;
  id_t    awid;
  addr_t  awaddr;
  len_t   awlen;
  burst_t awburst;
  logic   awvalid;
  logic   awready;
  data_t  wdata;
  strb_t  wstrb;
  logic   wlast;
  logic   wvalid;
  logic   wready;
  id_t    bid;
  resp_t  bresp;
  logic   bvalid;
  logic   bready;
  id_t    arid;
  addr_t  araddr;
  len_t   arlen;
  burst_t arburst;
  logic   arvalid;
  logic   arready;
  id_t    rid;
  data_t  rdata;
  resp_t  rresp;
  logic   rlast;
  logic   rvalid;
  logic   rready;

  row_t   rows [0:n_rows-1];
  data_t  ref_mem [0:mem_words-1];
  integer seed = 28;

  axi_mem_top #(
    .mem_addr_bits(mem_addr_bits)
  ) i_dut (
    .clock  (clock),
    .reset  (reset),
    .awid   (awid),
    .awaddr (awaddr),
    .awlen  (awlen),
    .awburst(awburst),
    .awvalid(awvalid),
    .awready(awready),
    .wdata  (wdata),
    .wstrb  (wstrb),
    .wlast  (wlast),
    .wvalid (wvalid),
    .wready (wready),
    .bid    (bid),
    .bresp  (bresp),
    .bvalid (bvalid),
    .bready (bready),
    .arid   (arid),
    .araddr (araddr),
    .arlen  (arlen),
    .arburst(arburst),
    .arvalid(arvalid),
    .arready(arready),
    .rid    (rid),
    .rdata  (rdata),
    .rresp  (rresp),
    .rlast  (rlast),
    .rvalid (rvalid),
    .rready (rready)
  );

  always #(clock_period / 2) clock = ~clock;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input data_t expected, input data_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH at %0t: %s expected %h actual %h",
                          $time, name, expected, actual));
    end
  endtask

  task automatic check_resp(input string name, input resp_t expected, input resp_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH at %0t: %s expected %b actual %b",
                          $time, name, expected, actual));
    end
  endtask

  task automatic check_id(input string name, input id_t expected, input id_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH at %0t: %s expected %h actual %h",
                          $time, name, expected, actual));
    end
  endtask

  task automatic check_last(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("MISMATCH at %0t: %s expected %b actual %b",
                          $time, name, expected, actual));
    end
  endtask

  // ready is high about one cycle in four under back-pressure
  function automatic logic next_ready(input bit stall);
    if (!stall) begin
      return 1'b1;
    end
    return ($random(seed) & 3) == 0;
  endfunction

  function automatic row_t make_row(input op_t kind, input id_t id, input addr_t addr,
                                    input len_t len, input burst_t burst,
                                    input logic [7:0] data_seed, input strb_t strb,
                                    input resp_t resp);
    return '{kind, id, addr, len, burst, data_seed, strb, resp};
  endfunction

  task automatic write_burst(input id_t id, input addr_t addr, input len_t len,
                             input burst_t burst, input logic [7:0] data_seed,
                             input strb_t strb, input resp_t exp_resp, input bit stall);
    addr_t word;
    data_t beat;
    logic  held;
    @(negedge clock);
    awid    = id;
    awaddr  = addr;
    awlen   = len;
    awburst = burst;
    awvalid = 1'b1;
    #1;
    while (!awready) begin
      @(negedge clock);
      #1;
    end
    @(negedge clock);
    awvalid = 1'b0;
    for (int i = 0; i <= len; i++) begin
      word   = (addr >> byte_offset_bits) + ((burst == burst_fixed) ? 0 : i);
      beat   = $random(seed) ^ {4{data_seed}};
      wdata  = beat;
      wstrb  = strb;
      wlast  = (i == len);
      wvalid = 1'b1;
      #1;
      while (!wready) begin
        @(negedge clock);
        #1;
      end
      if (word < mem_words) begin
        for (int b = 0; b < word_lanes; b++) begin
          if (strb[b]) begin
            ref_mem[word][b*8 +: 8] = beat[b*8 +: 8];
          end
        end
      end
      @(negedge clock);
    end
    wvalid = 1'b0;
    wlast  = 1'b0;
    held   = 1'b0;
    bready = next_ready(stall);
    #1;
    while (!(bvalid && bready)) begin
      // a held response must already be the final one
      if (bvalid) begin
        check_id("bid", id, bid);
        check_resp("bresp", exp_resp, bresp);
      end else if (held) begin
        abort_run($sformatf("bvalid dropped at %0t while a write response was held", $time));
      end
      held = bvalid;
      @(negedge clock);
      bready = next_ready(stall);
      #1;
    end
    check_id("bid", id, bid);
    check_resp("bresp", exp_resp, bresp);
    @(negedge clock);
    bready = 1'b0;
  endtask

  task automatic read_burst(input id_t id, input addr_t addr, input len_t len,
                            input burst_t burst, input bit stall);
    addr_t word;
    data_t exp_data;
    resp_t exp_resp;
    logic  held;
    @(negedge clock);
    arid    = id;
    araddr  = addr;
    arlen   = len;
    arburst = burst;
    arvalid = 1'b1;
    #1;
    while (!arready) begin
      @(negedge clock);
      #1;
    end
    @(negedge clock);
    arvalid = 1'b0;
    for (int i = 0; i <= len; i++) begin
      word     = (addr >> byte_offset_bits) + ((burst == burst_fixed) ? 0 : i);
      exp_data = (word < mem_words) ? ref_mem[word] : '0;
      exp_resp = (word < mem_words) ? resp_okay : resp_slverr;
      held     = 1'b0;
      rready   = next_ready(stall);
      #1;
      while (!(rvalid && rready)) begin
        if (rvalid) begin
          check_data("rdata", exp_data, rdata);
          check_resp("rresp", exp_resp, rresp);
          check_id("rid", id, rid);
          check_last("rlast", (i == len), rlast);
        end else if (held) begin
          abort_run($sformatf("rvalid dropped at %0t while a read beat was held", $time));
        end
        held = rvalid;
        @(negedge clock);
        rready = next_ready(stall);
        #1;
      end
      check_data("rdata", exp_data, rdata);
      check_resp("rresp", exp_resp, rresp);
      check_id("rid", id, rid);
      check_last("rlast", (i == len), rlast);
      @(negedge clock);
    end
    rready = 1'b0;
  endtask

  // watchdog
  initial begin
    #(n_rows * cycles_per_row * clock_period);
    abort_run($sformatf("run timed out after %0d cycles", n_rows * cycles_per_row));
  end

  initial begin
    row_t row;
    rows[0]  = make_row(op_write, 4'h1, 32'h0000_0000, 8'd0, burst_incr,  8'h11, 4'hf, resp_okay);
    rows[1]  = make_row(op_read,  4'h2, 32'h0000_0000, 8'd0, burst_incr,  8'h00, 4'h0, resp_okay);
    rows[2]  = make_row(op_write, 4'h3, 32'h0000_0004, 8'd0, burst_incr,  8'h22, 4'hf, resp_okay);
    rows[3]  = make_row(op_write, 4'h4, 32'h0000_0004, 8'd0, burst_incr,  8'h33, 4'h5, resp_okay);
    rows[4]  = make_row(op_read,  4'h5, 32'h0000_0004, 8'd0, burst_incr,  8'h00, 4'h0, resp_okay);
    rows[5]  = make_row(op_write, 4'h6, 32'h0000_0040, 8'd7, burst_incr,  8'h44, 4'hf, resp_okay);
    rows[6]  = make_row(op_read,  4'h7, 32'h0000_0040, 8'd7, burst_incr,  8'h00, 4'h0, resp_okay);
    rows[7]  = make_row(op_write, 4'h8, 32'h0000_0080, 8'd3, burst_fixed, 8'h55, 4'hf, resp_okay);
    rows[8]  = make_row(op_read,  4'h9, 32'h0000_0080, 8'd1, burst_fixed, 8'h00, 4'h0, resp_okay);
    // aliases word 0 if the range check were missing
    rows[9]  = make_row(op_write, 4'ha, 32'h0000_1000, 8'd0, burst_incr,  8'h66, 4'hf, resp_slverr);
    rows[10] = make_row(op_read,  4'hb, 32'h0000_0000, 8'd0, burst_incr,  8'h00, 4'h0, resp_okay);
    rows[11] = make_row(op_read,  4'hc, 32'h0000_1000, 8'd1, burst_incr,  8'h00, 4'h0, resp_okay);
    // last word then one past the end
    rows[12] = make_row(op_write, 4'hd, 32'h0000_0ffc, 8'd1, burst_incr,  8'h77, 4'hf, resp_slverr);
    rows[13] = make_row(op_read,  4'he, 32'h0000_0ffc, 8'd1, burst_incr,  8'h00, 4'h0, resp_okay);
    // read at addr and write at addr + 0x200 with both stalled
    rows[14] = make_row(op_both,  4'hf, 32'h0000_0040, 8'd7, burst_incr,  8'h88, 4'hf, resp_okay);
    rows[15] = make_row(op_read,  4'h1, 32'h0000_0240, 8'd7, burst_incr,  8'h00, 4'h0, resp_okay);

    clock   = 1'b0;
    reset   = 1'b1;
    awid    = '0;
    awaddr  = '0;
    awlen   = '0;
    awburst = burst_incr;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wlast   = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    arid    = '0;
    araddr  = '0;
    arlen   = '0;
    arburst = burst_incr;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (3) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    #1;
    if (!arready || !awready || rvalid || wready || bvalid) begin
      abort_run("handshake outputs are not in their idle state after reset");
    end

    for (int r = 0; r < n_rows; r++) begin
      row = rows[r];
      case (row.kind)
        op_write: begin
          write_burst(row.id, row.addr, row.len, row.burst, row.data_seed,
                      row.strb, row.resp, 1'b0);
        end
        op_read: begin
          read_burst(row.id, row.addr, row.len, row.burst, 1'b0);
        end
        default: begin
          fork
            write_burst(row.id, row.addr + 32'h200, row.len, row.burst, row.data_seed,
                        row.strb, row.resp, 1'b1);
            read_burst(row.id, row.addr, row.len, row.burst, 1'b1);
          join
        end
      endcase
    end

    repeat (2) @(negedge clock);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule
